// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = imageDisplayTb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a verdict"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/imageDisplayTb.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module imageDisplayTb;

	import imgPkg::*;

	localparam int ClkPeriod = 40;
	localparam int PopulatedWords = `BANK_COUNT * (2 ** `BANK_ADDR_BITS); // Banks 0 to 2
	localparam int FramePixels = `FRAME_WIDTH * `FRAME_HEIGHT;
	localparam int FrameCycles = `H_TOTAL * `V_TOTAL; // Includes blanking

	logic clk;
	logic rstN;
	viewMode_e mode;
	hostReq_t host;
	logic [`RES_WIDTH-1:0] readData;
	logic [`SRC_WIDTH-1:0] pixel;
	logic pixelActive;
	logic hsync;
	logic vsync;

	// Reference copy of both images that fills up as the host writes them
	logic [`SRC_WIDTH-1:0] srcModel [PopulatedWords];
	logic signed [`RES_WIDTH-1:0] resModel [PopulatedWords];
	string stimLines [$];
	bit stimLoaded = 1'b0; // Lets the watchdog size its limit
	int valueErrors = 0;
	int otherErrors = 0;

	imageDisplayTop dut_i (
		.clk(clk),
		.rstN(rstN),
		.mode(mode),
		.host(host),
		.readData(readData),
		.pixel(pixel),
		.pixelActive(pixelActive),
		.hsync(hsync),
		.vsync(vsync)
	);

	bind imageDisplayTop imageDisplayAssert assertInst (
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.pixelActive(pixelActive),
		.hsync(hsync),
		.vsync(vsync)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Negative sums go black and large sums go white
	function automatic logic [`SRC_WIDTH-1:0] saturateByte(input logic signed [`RES_WIDTH-1:0] v);
		return (v < 0) ? 8'd0 : ((v > 255) ? 8'd255 : v[`SRC_WIDTH-1:0]);
	endfunction

	// Returns the word a host read should see, and zero for unpopulated banks
	function automatic logic [`RES_WIDTH-1:0] modelRead(input int m, input int addr);
		if (addr >= PopulatedWords) begin
			return '0;
		end
		if (m == 0) begin
			return {{(`RES_WIDTH - `SRC_WIDTH){1'b0}}, srcModel[addr]};
		end
		return resModel[addr];
	endfunction

	task automatic checkValue(input string sigName, input logic [`RES_WIDTH-1:0] got,
			input logic [`RES_WIDTH-1:0] exp);
		assert (got === exp) else begin
			valueErrors++;
			$display("** Error at %0t ns: %s = 'h%0h, expected 'h%0h", $time, sigName, got, exp);
		end
	endtask

	// After the idle stretch the first line has to bring one hsync pulse of H_SYNC cycles
	task automatic checkFirstHsync();
		int waitCycles;
		int lowCycles;
		waitCycles = 0;
		lowCycles = 0;
		while (hsync !== 1'b0 && waitCycles < `H_TOTAL) begin
			@(negedge clk);
			waitCycles++;
		end
		while (hsync === 1'b0 && lowCycles <= `H_TOTAL) begin
			@(negedge clk);
			lowCycles++;
		end
		assert (lowCycles == `H_SYNC) else begin
			otherErrors++;
			$display("The first hsync pulse lasted %0d cycles instead of %0d",
				lowCycles, `H_SYNC);
		end
	endtask

	// Drives one write strobe that the caller releases later
	task automatic hostWrite(input int m, input int addr, input int value);
		@(negedge clk);
		mode = viewMode_e'(m);
		host.writeEnable = 1'b1;
		host.address = `PIX_ADDR_BITS'(addr);
		host.writeData = `RES_WIDTH'(value);
		if (addr < PopulatedWords && m == 0) begin
			srcModel[addr] = `SRC_WIDTH'(value); // Source banks keep the low byte
		end else if (addr < PopulatedWords) begin
			resModel[addr] = `RES_WIDTH'(value);
		end
	endtask

	task automatic releaseHost();
		@(negedge clk);
		host.writeEnable = 1'b0;
	endtask

	task automatic hostRead(input int m, input int addr, input bit hasFileValue, input int fileValue);
		logic [`RES_WIDTH-1:0] exp;
		@(negedge clk);
		mode = viewMode_e'(m);
		host.writeEnable = 1'b0;
		host.address = `PIX_ADDR_BITS'(addr);
		exp = modelRead(m, addr);
		repeat (2) @(negedge clk); // Read latency is fixed at two cycles
		checkValue("readData", readData, exp);
		if (hasFileValue) begin
			checkValue("readData", readData, `RES_WIDTH'(fileValue));
		end
	endtask

	// Kind 0 is a ramp over the whole address and kind 1 is random
	task automatic fillImage(input int m, input int kind);
		int value;
		for (int a = 0; a < PopulatedWords; a++) begin
			if (kind == 0) begin
				value = (m == 0) ? a + (a >> 8) * 85 : a - 300; // Result ramp crosses both limits
			end else begin
				value = (m == 0) ? int'($urandom_range(255)) : int'($urandom_range(1100)) - 400;
			end
			hostWrite(m, a, value);
		end
		releaseHost();
	endtask

	task automatic displayFrame(input int m);
		int n;
		logic [`SRC_WIDTH-1:0] exp;
		@(negedge clk);
		mode = viewMode_e'(m);
		// A frame starts once the vsync pulse is over
		do @(negedge clk); while (vsync !== 1'b0);
		do @(negedge clk); while (vsync !== 1'b1);
		n = 0;
		while (n < FramePixels) begin
			@(negedge clk);
			if (pixelActive === 1'b1) begin
				exp = (m == 0) ? srcModel[n] : saturateByte(resModel[n]);
				checkValue("pixel", `RES_WIDTH'(pixel), `RES_WIDTH'(exp));
				n++; // n-th visible pixel is linear address n
			end
		end
	endtask

	initial begin
		int fd;
		string line;
		byte opChar;
		int a;
		int b;
		int c;
		int fields;
		void'($urandom(32'h9599_e3bd));
		rstN = 1'b0;
		mode = viewSource;
		host = '0;

		fd = $fopen("bench/image_stim.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Could not open the stimulus file bench/image_stim.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					stimLines.push_back(line); // Comments and blank lines are dropped
				end
			end
			$fclose(fd);
		end
		stimLoaded = 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		checkValue("pixelActive", `RES_WIDTH'(pixelActive), '0); // Still the reset values here
		checkValue("pixel", `RES_WIDTH'(pixel), '0);
		checkValue("readData", readData, '0);
		// Syncs stay idle while the first visible stretch and front porch go by
		repeat (`FRAME_WIDTH + `H_FRONT) begin
			@(negedge clk);
			checkValue("hsync", `RES_WIDTH'(hsync), `RES_WIDTH'(1));
			checkValue("vsync", `RES_WIDTH'(vsync), `RES_WIDTH'(1));
		end
		checkFirstHsync();

		foreach (stimLines[i]) begin
			opChar = stimLines[i].getc(0);
			fields = $sscanf(stimLines[i].substr(1, stimLines[i].len() - 1), "%d %d %d", a, b, c);
			case (opChar)
				"F": fillImage(a, b);
				"W": begin
					hostWrite(a, b, c);
					releaseHost();
				end
				"R": hostRead(a, b, fields == 3, c); // Expected value is optional
				"D": displayFrame(a);
				default: begin
					otherErrors++;
					$display("Unknown operation in stimulus line: %s", stimLines[i]);
				end
			endcase
		end

		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Two frames per operation covers a fill or a frame search with room to spare
	initial begin
		longint limitNs;
		wait (stimLoaded);
		limitNs = longint'(stimLines.size() * 2 + 4) * FrameCycles * ClkPeriod;
		#(limitNs);
		otherErrors++;
		$display("Watchdog expired after %0d ns, the run did not finish", limitNs);
		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/imageDisplay_assert.sv
`timescale 1ns/1ps
`include "img_macros.svh"

// Checks on the timing outputs of imageDisplayTop
module imageDisplayAssert (
	input logic clk,
	input logic rstN,
	input logic [`SRC_WIDTH-1:0] pixel,
	input logic pixelActive,
	input logic hsync,
	input logic vsync
);

	// Both syncs are active low, so reset holds them high
	syncIdleInReset: assert property (@(posedge clk) !rstN |=> (hsync && vsync))
		else $error("hsync or vsync left idle level while in reset");

	// Blanking must show black
	blankPixelZero: assert property (@(posedge clk) disable iff (!rstN)
		!pixelActive |-> (pixel == '0))
		else $error("pixel is not zero outside the visible window");

	noActiveInHsync: assert property (@(posedge clk) disable iff (!rstN)
		!hsync |-> !pixelActive) // Sync sits inside horizontal blanking
		else $error("pixelActive is high during the hsync pulse");

endmodule

// File: bench/image_stim.txt
# Columns: op mode args, all numbers decimal, mode 0 source, 1 smooth, 2 edge, 3 sharpen
# F mode kind(0 ramp, 1 random) | W mode addr value | R mode addr [expected] | D mode
# Source image from a ramp, then spot writes and readback of the low byte
F 0 0
W 0 5 171
R 0 5 171
W 0 300 1023
R 0 300 255
W 0 600 -2
R 0 600 254
W 0 767 66
R 0 767 66
R 0 100
R 0 512
# Result image from a ramp that crosses both clamp limits
F 2 0
W 2 10 -131072
R 2 10 -131072
W 2 20 131071
R 2 20 131071
W 1 30 -5
R 3 30 -5
R 2 700
# Source contents survive the result writes
R 0 5 171
R 0 300 255
R 0 600 254
# Both images on screen
D 0
D 2
# Random contents, result values spread around the clamp range
F 0 1
F 2 1
D 0
D 3
# Bank index 3 is unpopulated
W 0 32 10
W 0 288 20
W 0 544 30
W 0 800 77
W 2 800 -9
R 0 800 0
R 2 800 0
R 0 1023 0
R 0 32 10
R 0 288 20
R 0 544 30
R 2 32
R 2 544

// File: filelist.f
+incdir+hw
hw/imgPkg.sv
hw/vgaTiming.sv
hw/frameBank.sv
hw/imageDrawer.sv
hw/imageDisplayTop.sv
bench/imageDisplay_assert.sv
bench/imageDisplayTb.sv

// File: hw/frameBank.sv
`timescale 1ns/1ps
`include "img_macros.svh"

// One bank of the frame store
// The host side reads and writes, the display side only reads
module frameBank #(
	parameter int DataWidth = 8
) (
	input logic clk,
	input logic [`BANK_ADDR_BITS-1:0] hostAddr,
	input logic hostWe,
	input logic [DataWidth-1:0] hostWrData,
	output logic [DataWidth-1:0] hostRdData,
	input logic [`BANK_ADDR_BITS-1:0] dispAddr,
	output logic [DataWidth-1:0] dispRdData
);

	logic [DataWidth-1:0] mem [2**`BANK_ADDR_BITS]; // Contents undefined until written

	// Host port, the read returns the old word when the same address is written
	always_ff @(posedge clk) begin
		hostRdData <= mem[hostAddr];
		if (hostWe) begin
			mem[hostAddr] <= hostWrData;
		end
	end

	// Display port reads every cycle
	always_ff @(posedge clk) begin
		dispRdData <= mem[dispAddr];
	end

endmodule

// File: hw/imageDisplayTop.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module imageDisplayTop (
	input logic clk,
	input logic rstN,
	input imgPkg::viewMode_e mode,
	input imgPkg::hostReq_t host,
	output logic [`RES_WIDTH-1:0] readData,
	output logic [`SRC_WIDTH-1:0] pixel,
	output logic pixelActive,
	output logic hsync,
	output logic vsync
);

	import imgPkg::*;

	// Timing levels that have to stay aligned with the pixel stream
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
	} syncBits_t;

	rasterPos_t pos;
	logic rawHsync; // Straight from the scanner, PIPE_DEPTH cycles early
	logic rawVsync;
	syncBits_t syncPipe [`PIPE_DEPTH];

	vgaTiming timingInst (
		.clk(clk),
		.rstN(rstN),
		.pos(pos),
		.hsync(rawHsync),
		.vsync(rawVsync)
	);

	imageDrawer drawerInst (
		.clk(clk),
		.rstN(rstN),
		.mode(mode),
		.host(host),
		.pos(pos),
		.pixel(pixel),
		.readData(readData)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `PIPE_DEPTH; i++) begin
				syncPipe[i] <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0}; // Syncs idle high
			end
		end else begin
			syncPipe[0] <= '{hsync: rawHsync, vsync: rawVsync, active: pos.active};
			for (int i = 1; i < `PIPE_DEPTH; i++) begin
				syncPipe[i] <= syncPipe[i-1];
			end
		end
	end

	// Last stage lines up with the drawer's output register
	assign hsync = syncPipe[`PIPE_DEPTH-1].hsync;
	assign vsync = syncPipe[`PIPE_DEPTH-1].vsync;
	assign pixelActive = syncPipe[`PIPE_DEPTH-1].active;

endmodule

// File: hw/imageDrawer.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module imageDrawer (
	input logic clk,
	input logic rstN,
	input imgPkg::viewMode_e mode,
	input imgPkg::hostReq_t host,
	input imgPkg::rasterPos_t pos,
	output logic [`SRC_WIDTH-1:0] pixel,
	output logic [`RES_WIDTH-1:0] readData
);

	import imgPkg::*;

	logic [`PIX_ADDR_BITS-1:0] dispLinear; // Raster position as a linear pixel address
	logic [`BANK_SEL_BITS-1:0] dispBank;
	logic [`BANK_ADDR_BITS-1:0] dispAddr;
	logic [`BANK_SEL_BITS-1:0] hostBank;
	logic [`BANK_ADDR_BITS-1:0] hostAddr;

	logic [`BANK_COUNT-1:0] srcWe; // One strobe per populated bank
	logic [`BANK_COUNT-1:0] resWe;

	logic [`SRC_WIDTH-1:0] srcHostRd [`BANK_COUNT];
	logic [`SRC_WIDTH-1:0] srcDispRd [`BANK_COUNT];
	logic [`RES_WIDTH-1:0] resHostRd [`BANK_COUNT];
	logic [`RES_WIDTH-1:0] resDispRd [`BANK_COUNT];

	// Stage 1 follows the RAM read so the mux sees matching bank outputs
	logic [`BANK_SEL_BITS-1:0] dispBankQ;
	logic [`BANK_SEL_BITS-1:0] hostBankQ;
	logic activeQ;
	viewMode_e modeQ;

	logic [`SRC_WIDTH-1:0] srcPixSel;
	logic [`RES_WIDTH-1:0] resPixSel;
	logic [`SRC_WIDTH-1:0] srcHostSel;
	logic [`RES_WIDTH-1:0] resHostSel;

	// Saturate a signed filter sum into the grey-scale range
	function automatic logic [`SRC_WIDTH-1:0] clampPix(input logic signed [`RES_WIDTH-1:0] v);
		if (v < 0) begin
			return '0;
		end else if (v > 255) begin
			return 8'd255;
		end else begin
			return v[`SRC_WIDTH-1:0];
		end
	endfunction

	// Blanking reads address zero, the result is masked later anyway
	assign dispLinear = pos.active
		? `PIX_ADDR_BITS'(pos.vcount * `FRAME_WIDTH + pos.hcount) : '0;
	assign {dispBank, dispAddr} = dispLinear;
	assign {hostBank, hostAddr} = host.address;

	// Mode picks the image, the upper address bits pick the bank
	always_comb begin
		for (int b = 0; b < `BANK_COUNT; b++) begin
			srcWe[b] = host.writeEnable && (hostBank == `BANK_SEL_BITS'(b))
				&& (mode == viewSource);
			resWe[b] = host.writeEnable && (hostBank == `BANK_SEL_BITS'(b))
				&& (mode != viewSource);
		end
	end

	for (genvar g = 0; g < `BANK_COUNT; g++) begin : gBank
		// Unprocessed image, the host writes only its low byte
		frameBank #(.DataWidth(`SRC_WIDTH)) srcBank (
			.clk(clk),
			.hostAddr(hostAddr),
			.hostWe(srcWe[g]),
			.hostWrData(host.writeData[`SRC_WIDTH-1:0]),
			.hostRdData(srcHostRd[g]),
			.dispAddr(dispAddr),
			.dispRdData(srcDispRd[g])
		);

		frameBank #(.DataWidth(`RES_WIDTH)) resBank ( // Filter results, stored raw
			.clk(clk),
			.hostAddr(hostAddr),
			.hostWe(resWe[g]),
			.hostWrData(host.writeData),
			.hostRdData(resHostRd[g]),
			.dispAddr(dispAddr),
			.dispRdData(resDispRd[g])
		);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dispBankQ <= '0;
			hostBankQ <= '0;
			activeQ <= 1'b0;
			modeQ <= viewSource;
		end else begin
			dispBankQ <= dispBank;
			hostBankQ <= hostBank;
			activeQ <= pos.active;
			modeQ <= mode;
		end
	end

	// An unpopulated bank index matches nothing and falls through as zero
	always_comb begin
		srcPixSel = '0;
		resPixSel = '0;
		srcHostSel = '0;
		resHostSel = '0;
		for (int b = 0; b < `BANK_COUNT; b++) begin
			if (dispBankQ == `BANK_SEL_BITS'(b)) begin
				srcPixSel = srcDispRd[b];
				resPixSel = resDispRd[b];
			end
			if (hostBankQ == `BANK_SEL_BITS'(b)) begin
				srcHostSel = srcHostRd[b];
				resHostSel = resHostRd[b];
			end
		end
	end

	// Output stage, two cycles after the address
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pixel <= '0;
			readData <= '0;
		end else begin
			if (!activeQ) begin
				pixel <= '0; // Blank outside the visible window
			end else if (modeQ == viewSource) begin
				pixel <= srcPixSel;
			end else begin
				pixel <= clampPix(resPixSel);
			end

			if (modeQ == viewSource) begin
				readData <= `RES_WIDTH'(srcHostSel); // Zero-extended byte
			end else begin
				readData <= resHostSel; // Raw signed word
			end
		end
	end

endmodule

// File: hw/imgPkg.sv
`include "img_macros.svh"

package imgPkg;

	// The kernel selection doubles as the view mode
	// Only viewSource shows the raw image, the others all show the result banks
	typedef enum logic [1:0] {
		viewSource = 2'd0,
		viewSmooth = 2'd1,
		viewEdge = 2'd2,
		viewSharpen = 2'd3
	} viewMode_e;

	// One host operation per cycle
	// A read needs no strobe, the address alone is enough
	typedef struct packed {
		logic writeEnable; // Write strobe, sampled on the rising edge
		logic [`PIX_ADDR_BITS-1:0] address; // Bank index in the upper bits
		logic signed [`RES_WIDTH-1:0] writeData; // Source banks only keep the low byte
	} hostReq_t;

	// Where the scanner is right now
	typedef struct packed {
		logic [`COUNT_BITS-1:0] hcount; // Column, counts through blanking too
		logic [`COUNT_BITS-1:0] vcount; // Line, counts through blanking too
		logic active; // Inside the visible window
	} rasterPos_t;

endpackage

// File: hw/img_macros.svh
`ifndef IMG_MACROS_SVH
`define IMG_MACROS_SVH

// Visible frame, shrunk so that a whole frame fits in a short simulation
`define FRAME_WIDTH 32
`define FRAME_HEIGHT 24

`define H_FRONT 4 // Horizontal blanking in pixel clocks
`define H_SYNC 4
`define H_BACK 8
`define V_FRONT 1 // Vertical blanking in lines
`define V_SYNC 2
`define V_BACK 2

`define H_TOTAL (`FRAME_WIDTH + `H_FRONT + `H_SYNC + `H_BACK)
`define V_TOTAL (`FRAME_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK)
`define COUNT_BITS 10 // Width of the raster counters

`define BANK_ADDR_BITS 8 // Words per bank are 2**BANK_ADDR_BITS
`define BANK_SEL_BITS 2
`define BANK_COUNT 3 // Indices at or above this are unpopulated
`define PIX_ADDR_BITS (`BANK_SEL_BITS + `BANK_ADDR_BITS)

`define SRC_WIDTH 8 // Grey-scale source pixel
`define RES_WIDTH 18 // Signed filter sum
`define PIPE_DEPTH 2 // Raster position to pixel, in cycles

`endif

// File: hw/vgaTiming.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module vgaTiming (
	input logic clk,
	input logic rstN,
	output imgPkg::rasterPos_t pos,
	output logic hsync,
	output logic vsync
);

	logic [`COUNT_BITS-1:0] hCnt; // Free-running column counter
	logic [`COUNT_BITS-1:0] vCnt; // Free-running line counter
	logic hVisible;
	logic vVisible;
	logic hSyncWin;
	logic vSyncWin;
	logic lineEnd;
	logic frameEnd;

	// Visible area comes first in each line, then front porch, sync and back porch
	always_comb begin
		hVisible = hCnt < `FRAME_WIDTH;
		vVisible = vCnt < `FRAME_HEIGHT;
		hSyncWin = (hCnt >= `FRAME_WIDTH + `H_FRONT)
			&& (hCnt < `FRAME_WIDTH + `H_FRONT + `H_SYNC);
		vSyncWin = (vCnt >= `FRAME_HEIGHT + `V_FRONT)
			&& (vCnt < `FRAME_HEIGHT + `V_FRONT + `V_SYNC);
		lineEnd = hCnt == `H_TOTAL - 1;
		frameEnd = vCnt == `V_TOTAL - 1;
	end

	// Outputs are the counts of the previous cycle, so pixel (0,0) shows right after reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			hCnt <= '0;
			vCnt <= '0;
			pos <= '0;
			hsync <= 1'b1; // Syncs are active low
			vsync <= 1'b1;
		end else begin
			pos.hcount <= hCnt;
			pos.vcount <= vCnt;
			pos.active <= hVisible && vVisible;
			hsync <= !hSyncWin;
			vsync <= !vSyncWin;

			if (lineEnd) begin
				hCnt <= '0;
				// Line counter only moves when a line wraps
				if (frameEnd) begin
					vCnt <= '0;
				end else begin
					vCnt <= vCnt + 1'b1;
				end
			end else begin
				hCnt <= hCnt + 1'b1;
			end
		end
	end

endmodule
